/* build.f */
+incdir+source
source/bru_pkg.sv
source/md_ctrl.sv
source/cycle_counter.sv
source/md_datapath.sv
source/branch_forward.sv
source/branch_resolve.sv
source/bru_top.sv
test/bru_asserts.sv
test/bru_tb.sv

/* source/branch_forward.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bru_consts.svh"

module branch_forward
  import bru_pkg::*;
(
  input  wire br_req_t                 br,
  input  wire ex_mem_t                 ex_mem,
  input  wire mem_wb_t                 mem_wb,
  input  wire logic                    md_done,
  input  wire md_op_e                  md_op,
  input  wire logic [`BRU_REG_AW-1:0]  md_rd,
  input  wire logic [`BRU_XLEN-1:0]    md_result,
  output logic [`BRU_XLEN-1:0]         rs1_mod,
  output logic [`BRU_XLEN-1:0]         rs2_mod,
  output logic                         hazard
);

  logic                 md_hit;
  logic [`BRU_XLEN-1:0] exres;
  logic                 ex_fwd_ok;
  logic                 ex1;
  logic                 ex2;
  logic                 wb1;
  logic                 wb2;

  // Finished mul/div result stands in for the ALU value
  assign md_hit = md_done && (md_rd == ex_mem.rd);

  always_comb begin
    exres = ex_mem.alures;
    if (md_hit) begin
      case (md_op)
        MD_MUL, MD_DIVU, MD_REMU: exres = md_result;
        default:                  exres = ex_mem.alures;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Index matching that never forwards x0
  //////////////////////////////////////////////////////////////////////

  // EX/MEM forwards only ALU-type writes
  assign ex_fwd_ok = ex_mem.regwrite && !ex_mem.memread;

  assign ex1 = (br.rs1 != '0) && (br.rs1 == ex_mem.rd) && ex_fwd_ok;
  assign ex2 = (br.rs2 != '0) && (br.rs2 == ex_mem.rd) && ex_fwd_ok;
  assign wb1 = (br.rs1 != '0) && (br.rs1 == mem_wb.rd) && mem_wb.regwrite;
  assign wb2 = (br.rs2 != '0) && (br.rs2 == mem_wb.rd) && mem_wb.regwrite;

  // Newest value wins
  assign rs1_mod = ex1 ? exres : (wb1 ? mem_wb.wbres : br.rs1_val);
  assign rs2_mod = ex2 ? exres : (wb2 ? mem_wb.wbres : br.rs2_val);

  // Load still in EX/MEM with its data not yet available
  assign hazard = ex_mem.memread && ex_mem.regwrite && (ex_mem.rd != '0) &&
                  ((ex_mem.rd == br.rs1) || (ex_mem.rd == br.rs2));

endmodule : branch_forward

`default_nettype wire

/* source/branch_resolve.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bru_consts.svh"

module branch_resolve
  import bru_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire logic                  req_valid,
  output logic                       req_ready,
  input  wire br_req_t               br,
  input  wire logic                  hazard,
  input  wire logic [`BRU_XLEN-1:0]  rs1_mod,
  input  wire logic [`BRU_XLEN-1:0]  rs2_mod,
  output logic                       resp_valid,
  output br_resp_t                   resp
);

  logic accept;
  logic taken;

  // Stall while a load result is outstanding
  assign req_ready = !hazard;
  assign accept    = req_valid && req_ready;

  //////////////////////////////////////////////////////////////////////
  // Compare
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (br.op)
      BR_EQ:   taken = (rs1_mod == rs2_mod);
      BR_NE:   taken = (rs1_mod != rs2_mod);
      BR_LTU:  taken = (rs1_mod < rs2_mod);
      BR_GEU:  taken = (rs1_mod >= rs2_mod);
      BR_LT:   taken = ($signed(rs1_mod) < $signed(rs2_mod));
      BR_GE:   taken = ($signed(rs1_mod) >= $signed(rs2_mod));
      default: taken = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Registered outcome
  //////////////////////////////////////////////////////////////////////

  // Pulse for one cycle after accept
  always_ff @(posedge clk) begin
    if (reset) begin
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      resp.taken  <= taken;
      resp.target <= br.pc + br.imm;
    end
  end

endmodule : branch_resolve

`default_nettype wire

/* source/bru_consts.svh */
`ifndef BRU_CONSTS_SVH
`define BRU_CONSTS_SVH

// Data path width
`define BRU_XLEN 32

// Register index width, x0..x31
`define BRU_REG_AW 5

// One iteration per result bit
`define BRU_MD_STEPS 32

`endif

/* source/bru_pkg.sv */
`default_nettype none

`include "bru_consts.svh"

package bru_pkg;

  // Multiply/divide opcodes, unsigned only
  typedef enum logic [1:0] {
    MD_MUL  = 2'd0,
    MD_DIVU = 2'd1,
    MD_REMU = 2'd2
  } md_op_e;

  // Controller states
  typedef enum logic [1:0] {
    MD_IDLE = 2'd0,
    MD_BUSY = 2'd1,
    MD_DONE = 2'd2
  } md_state_e;

  // Branch compare kinds
  typedef enum logic [2:0] {
    BR_EQ  = 3'd0,
    BR_NE  = 3'd1,
    BR_LTU = 3'd2,
    BR_GEU = 3'd3,
    BR_LT  = 3'd4,
    BR_GE  = 3'd5
  } br_op_e;

  typedef struct packed {
    md_op_e                  op;
    logic [`BRU_XLEN-1:0]    a;
    logic [`BRU_XLEN-1:0]    b;
    logic [`BRU_REG_AW-1:0]  rd;   // Index the result forwards under
  } md_req_t;

  typedef struct packed {
    br_op_e                  op;
    logic [`BRU_REG_AW-1:0]  rs1;
    logic [`BRU_REG_AW-1:0]  rs2;
    logic [`BRU_XLEN-1:0]    rs1_val;
    logic [`BRU_XLEN-1:0]    rs2_val;
    logic [`BRU_XLEN-1:0]    pc;
    logic [`BRU_XLEN-1:0]    imm;
  } br_req_t;

  // EX/MEM pipeline register snapshot
  typedef struct packed {
    logic [`BRU_REG_AW-1:0]  rd;
    logic                    regwrite;
    logic                    memread;
    logic [`BRU_XLEN-1:0]    alures;
  } ex_mem_t;

  // MEM/WB pipeline register snapshot
  typedef struct packed {
    logic [`BRU_REG_AW-1:0]  rd;
    logic                    regwrite;
    logic [`BRU_XLEN-1:0]    wbres;
  } mem_wb_t;

  typedef struct packed {
    logic                    taken;
    logic [`BRU_XLEN-1:0]    target;
  } br_resp_t;

endpackage : bru_pkg

`default_nettype wire

/* source/bru_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bru_consts.svh"

module bru_top
  import bru_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire logic                  md_req_valid,
  input  wire md_req_t               md_req,
  output logic                       md_req_ready,
  output logic                       md_res_valid,
  output logic [`BRU_XLEN-1:0]       md_res,
  input  wire logic                  md_res_ready,
  input  wire logic                  br_req_valid,
  input  wire br_req_t               br_req,
  output logic                       br_req_ready,
  input  wire ex_mem_t               ex_mem,
  input  wire mem_wb_t               mem_wb,
  output logic                       br_resp_valid,
  output br_resp_t                   br_resp
);

  logic                    md_load;
  logic                    md_step;
  logic                    md_last;
  md_state_e               md_state;
  md_op_e                  md_op_q;
  logic [`BRU_REG_AW-1:0]  md_rd;
  logic [`BRU_XLEN-1:0]    rs1_mod;
  logic [`BRU_XLEN-1:0]    rs2_mod;
  logic                    hazard;

  //////////////////////////////////////////////////////////////////////
  // Multiply/divide unit
  //////////////////////////////////////////////////////////////////////

  md_ctrl ctrl_i (
    .clk       (clk),
    .reset     (reset),
    .req_valid (md_req_valid),
    .req_ready (md_req_ready),
    .res_valid (md_res_valid),
    .res_ready (md_res_ready),
    .step_last (md_last),
    .load      (md_load),
    .step      (md_step),
    .state     (md_state)
  );

  cycle_counter cnt_i (
    .clk   (clk),
    .reset (reset),
    .load  (md_load),
    .step  (md_step),
    .last  (md_last)
  );

  md_datapath dp_i (
    .clk    (clk),
    .load   (md_load),
    .step   (md_step),
    .req    (md_req),
    .result (md_res),
    .rd     (md_rd)
  );

  // Opcode of the operation in flight, for the forward select
  always_ff @(posedge clk) begin
    if (md_load) md_op_q <= md_req.op;
  end

  //////////////////////////////////////////////////////////////////////
  // Branch path
  //////////////////////////////////////////////////////////////////////

  branch_forward fwd_i (
    .br        (br_req),
    .ex_mem    (ex_mem),
    .mem_wb    (mem_wb),
    .md_done   (md_state == MD_DONE),
    .md_op     (md_op_q),
    .md_rd     (md_rd),
    .md_result (md_res),
    .rs1_mod   (rs1_mod),
    .rs2_mod   (rs2_mod),
    .hazard    (hazard)
  );

  branch_resolve res_i (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (br_req_valid),
    .req_ready  (br_req_ready),
    .br         (br_req),
    .hazard     (hazard),
    .rs1_mod    (rs1_mod),
    .rs2_mod    (rs2_mod),
    .resp_valid (br_resp_valid),
    .resp       (br_resp)
  );

endmodule : bru_top

`default_nettype wire

/* source/cycle_counter.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bru_consts.svh"

module cycle_counter (
  input  wire logic  clk,
  input  wire logic  reset,
  input  wire logic  load,
  input  wire logic  step,
  output logic       last
);

  // Wide enough to hold the full step count
  localparam int CNT_W = $clog2(`BRU_MD_STEPS + 1);

  logic [CNT_W-1:0] count;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (load) begin
      count <= CNT_W'(`BRU_MD_STEPS);
    end else if (step && (count != '0)) begin
      count <= count - 1'b1;
    end
  end

  // Final step is the one that empties the counter
  assign last = step && (count == CNT_W'(1));

endmodule : cycle_counter

`default_nettype wire

/* source/md_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module md_ctrl
  import bru_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      reset,
  input  wire logic      req_valid,
  output logic           req_ready,
  output logic           res_valid,
  input  wire logic      res_ready,
  input  wire logic      step_last,
  output logic           load,
  output logic           step,
  output md_state_e      state
);

  md_state_e state_next;

  //////////////////////////////////////////////////////////////////////
  // Handshake and datapath strobes
  //////////////////////////////////////////////////////////////////////

  // Only an idle unit takes new work
  assign req_ready = (state == MD_IDLE);
  assign load      = req_valid && req_ready;

  // One iteration per busy cycle
  assign step = (state == MD_BUSY);

  // Result held stable for the whole DONE state
  assign res_valid = (state == MD_DONE);

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      MD_IDLE: begin
        if (load) state_next = MD_BUSY;
      end
      MD_BUSY: begin
        // Counter flags the final iteration
        if (step_last) state_next = MD_DONE;
      end
      MD_DONE: begin
        // Back-pressure keeps us here
        if (res_ready) state_next = MD_IDLE;
      end
      default: state_next = MD_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= MD_IDLE;
    end else begin
      state <= state_next;
    end
  end

endmodule : md_ctrl

`default_nettype wire

/* source/md_datapath.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bru_consts.svh"

module md_datapath
  import bru_pkg::*;
(
  input  wire logic                    clk,
  input  wire logic                    load,
  input  wire logic                    step,
  input  wire md_req_t                 req,
  output logic [`BRU_XLEN-1:0]         result,
  output logic [`BRU_REG_AW-1:0]       rd
);

  // hi: product accumulator or partial remainder
  // lo: multiplier or dividend shifting into quotient
  // b:  multiplicand (shifts left) or divisor (fixed)
  logic [`BRU_XLEN-1:0] hi_q;
  logic [`BRU_XLEN-1:0] lo_q;
  logic [`BRU_XLEN-1:0] b_q;
  md_op_e               op_q;

  // Restoring divide, one extra bit catches the borrow
  logic [`BRU_XLEN:0]   rem_shift;
  logic [`BRU_XLEN:0]   rem_diff;

  assign rem_shift = {hi_q, lo_q[`BRU_XLEN-1]};
  assign rem_diff  = rem_shift - {1'b0, b_q};

  //////////////////////////////////////////////////////////////////////
  // Iteration registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (load) begin
      op_q <= req.op;
      rd   <= req.rd;
      hi_q <= '0;
      lo_q <= req.a;
      b_q  <= req.b;
    end else if (step) begin
      if (op_q == MD_MUL) begin
        // Shift-add, low half only
        if (lo_q[0]) hi_q <= hi_q + b_q;
        b_q  <= b_q << 1;
        lo_q <= lo_q >> 1;
      end else if (!rem_diff[`BRU_XLEN]) begin
        // Divisor fits, keep the difference
        hi_q <= rem_diff[`BRU_XLEN-1:0];
        lo_q <= {lo_q[`BRU_XLEN-2:0], 1'b1};
      end else begin
        // Restore
        hi_q <= rem_shift[`BRU_XLEN-1:0];
        lo_q <= {lo_q[`BRU_XLEN-2:0], 1'b0};
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////////////////////////

  // Zero divisor: every trial subtract succeeds, so the quotient ends
  // all ones and the remainder is the untouched dividend
  always_comb begin
    case (op_q)
      MD_MUL:  result = hi_q;
      MD_DIVU: result = lo_q;
      MD_REMU: result = hi_q;
      default: result = hi_q;
    endcase
  end

endmodule : md_datapath

`default_nettype wire

/* test/bru_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bru_consts.svh"

module bru_asserts
  import bru_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire logic                  md_req_valid,
  input  wire logic                  md_req_ready,
  input  wire logic                  md_res_valid,
  input  wire logic [`BRU_XLEN-1:0]  md_res,
  input  wire logic                  md_res_ready,
  input  wire logic                  br_req_valid,
  input  wire logic                  br_req_ready,
  input  wire br_req_t               br_req,
  input  wire ex_mem_t               ex_mem,
  input  wire logic                  br_resp_valid
);

  // Assertion failures seen so far
  int fails = 0;

  // Accepted operation not yet handed back
  logic md_pending;

  // Source index waiting on the load in EX/MEM
  logic rs1_waits;
  logic rs2_waits;

  always_ff @(posedge clk) begin
    if (reset) begin
      md_pending <= 1'b0;
    end else if (md_req_valid && md_req_ready) begin
      md_pending <= 1'b1;
    end else if (md_res_valid && md_res_ready) begin
      md_pending <= 1'b0;
    end
  end

  assign rs1_waits = (br_req.rs1 != '0) && (br_req.rs1 == ex_mem.rd);
  assign rs2_waits = (br_req.rs2 != '0) && (br_req.rs2 == ex_mem.rd);

  //////////////////////////////////////////////////////////////////////
  // Multiply/divide handshake
  //////////////////////////////////////////////////////////////////////

  // Busy or done unit takes no new work
  a_md_ready_idle: assert property (@(posedge clk) disable iff (reset)
    md_pending |-> !md_req_ready)
    else begin
      $error("md_req_ready high outside MD_IDLE");
      fails++;
    end

  // Result stays put under back-pressure
  a_md_res_hold: assert property (@(posedge clk) disable iff (reset)
    (md_res_valid && !md_res_ready) |=> (md_res_valid && $stable(md_res)))
    else begin
      $error("md_res dropped or changed before handshake");
      fails++;
    end

  // One step per bit before the result shows up
  a_md_latency: assert property (@(posedge clk) disable iff (reset)
    (md_req_valid && md_req_ready) |=>
      !md_res_valid [*`BRU_MD_STEPS] ##1 md_res_valid)
    else begin
      $error("md_res_valid not raised at the expected cycle");
      fails++;
    end

  //////////////////////////////////////////////////////////////////////
  // Branch path
  //////////////////////////////////////////////////////////////////////

  a_br_resp_after_accept: assert property (@(posedge clk) disable iff (reset)
    (br_req_valid && br_req_ready) |=> br_resp_valid)
    else begin
      $error("br_resp_valid missing one cycle after accept");
      fails++;
    end

  // No pulse without an accept
  a_br_resp_only_after_accept: assert property (@(posedge clk) disable iff (reset)
    !(br_req_valid && br_req_ready) |=> !br_resp_valid)
    else begin
      $error("br_resp_valid without a preceding accept");
      fails++;
    end

  a_br_stall_on_hazard: assert property (@(posedge clk) disable iff (reset)
    (ex_mem.memread && ex_mem.regwrite && (rs1_waits || rs2_waits)) |-> !br_req_ready)
    else begin
      $error("br_req_ready high during a load hazard");
      fails++;
    end

endmodule : bru_asserts

bind bru_top bru_asserts asserts_i (
  .clk           (clk),
  .reset         (reset),
  .md_req_valid  (md_req_valid),
  .md_req_ready  (md_req_ready),
  .md_res_valid  (md_res_valid),
  .md_res        (md_res),
  .md_res_ready  (md_res_ready),
  .br_req_valid  (br_req_valid),
  .br_req_ready  (br_req_ready),
  .br_req        (br_req),
  .ex_mem        (ex_mem),
  .br_resp_valid (br_resp_valid)
);

`default_nettype wire

/* test/bru_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bru_consts.svh"

module bru_tb
  import bru_pkg::*;
();

  localparam int TIMEOUT = 100;

  logic                  clk;
  logic                  reset;
  logic                  md_req_valid;
  md_req_t               md_req;
  logic                  md_req_ready;
  logic                  md_res_valid;
  logic [`BRU_XLEN-1:0]  md_res;
  logic                  md_res_ready;
  logic                  br_req_valid;
  br_req_t               br_req;
  logic                  br_req_ready;
  ex_mem_t               ex_mem;
  mem_wb_t               mem_wb;
  logic                  br_resp_valid;
  br_resp_t              br_resp;

  integer seed;
  int     errors;
  int     tests_run;
  int     tests_failed;
  int     test_err0;
  bit     timed_out;

  bru_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Unsigned only with RISC-V divide-by-zero results
  function automatic logic [31:0] md_model(md_op_e op, logic [31:0] a, logic [31:0] b);
    logic [31:0] r;
    case (op)
      MD_MUL:  r = a * b;
      MD_DIVU: r = (b == 0) ? 32'hffff_ffff : a / b;
      default: r = (b == 0) ? a : a % b;
    endcase
    return r;
  endfunction

  // Signed compares decided on the sign bits first
  function automatic logic br_model(br_op_e op, logic [31:0] a, logic [31:0] b);
    logic t;
    case (op)
      BR_EQ:   t = (a == b);
      BR_NE:   t = (a != b);
      BR_LTU:  t = (a < b);
      BR_GEU:  t = !(a < b);
      BR_LT:   t = (a[31] != b[31]) ? a[31] : (a < b);
      default: t = (a[31] != b[31]) ? b[31] : !(a < b);
    endcase
    return t;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Checks and bookkeeping
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH t=%0t %s expected %h got %h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic note_timeout(string what);
    $display("timeout at t=%0t while waiting for %s", $time, what);
    timed_out = 1'b1;
    errors++;
  endtask

  task automatic close_test(string name);
    tests_run++;
    if (errors != test_err0) begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, name, errors - test_err0);
    end else if (timed_out) begin
      $display("test %0d %s: skipped", tests_run, name);
    end else begin
      $display("test %0d %s: ok", tests_run, name);
    end
    test_err0 = errors;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Multiply/divide channel
  //////////////////////////////////////////////////////////////////////

  task automatic md_issue(md_req_t req);
    int n;
    md_req       <= req;
    md_req_valid <= 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!md_req_ready && n < TIMEOUT);
    md_req_valid <= 1'b0;
    if (!md_req_ready) note_timeout("md_req_ready");
  endtask

  task automatic md_wait_result();
    int n;
    n = 0;
    while (!md_res_valid && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (!md_res_valid) note_timeout("md_res_valid");
  endtask

  // Withhold ready for a while and then take the result
  task automatic md_release(logic [31:0] exp, int hold);
    repeat (hold) begin
      check_value("md_res_valid", md_res_valid, 1);
      check_value("md_res", md_res, exp);
      @(posedge clk);
    end
    check_value("md_res", md_res, exp);
    md_res_ready <= 1'b1;
    @(posedge clk);
    md_res_ready <= 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Branch channel
  //////////////////////////////////////////////////////////////////////

  // op1/op2 are the operands the compare should end up using
  task automatic send_branch(br_req_t req, logic [31:0] op1, logic [31:0] op2);
    int n;
    logic exp_taken;
    logic [31:0] exp_target;
    exp_taken  = br_model(req.op, op1, op2);
    exp_target = req.pc + req.imm;
    br_req       <= req;
    br_req_valid <= 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!br_req_ready && n < TIMEOUT);
    br_req_valid <= 1'b0;
    if (!br_req_ready) begin
      note_timeout("br_req_ready");
      return;
    end
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!br_resp_valid && n < TIMEOUT);
    if (!br_resp_valid) begin
      note_timeout("br_resp_valid");
      return;
    end
    check_value("br_resp.taken", br_resp.taken, exp_taken);
    check_value("br_resp.target", br_resp.target, exp_target);
  endtask

  // Offer a branch behind a load and expect it to sit there
  task automatic hold_stalled(br_req_t req);
    br_req       <= req;
    br_req_valid <= 1'b1;
    repeat (4) begin
      @(posedge clk);
      check_value("br_req_ready", br_req_ready, 0);
      check_value("br_resp_valid", br_resp_valid, 0);
    end
  endtask

  function automatic br_req_t random_branch(br_op_e op);
    br_req_t req;
    req.op      = op;
    req.rs1     = 5'($random(seed));
    req.rs2     = 5'($random(seed));
    req.rs1_val = $random(seed);
    req.rs2_val = $random(seed);
    req.pc      = $random(seed) & 32'hffff_fffc;
    req.imm     = $random(seed);
    return req;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_md_ops();
    md_req_t req;
    logic [31:0] exp;
    // Reset state
    check_value("md_req_ready", md_req_ready, 1);
    check_value("md_res_valid", md_res_valid, 0);
    check_value("br_resp_valid", br_resp_valid, 0);
    for (int i = 0; i < 12; i++) begin
      req.op = md_op_e'(i % 3);
      req.a  = $random(seed);
      // Divisors go full width then small then zero
      if (i < 3) req.b = $random(seed);
      else if (i < 9) req.b = ($random(seed) & 32'h0000_ffff) | 32'h1;
      else req.b = '0;
      req.rd = 5'(i + 1);
      exp = md_model(req.op, req.a, req.b);
      md_issue(req);
      if (timed_out) return;
      md_wait_result();
      if (timed_out) return;
      md_release(exp, i % 4 + 2);
    end
  endtask

  task automatic test_plain_branches();
    br_req_t req;
    ex_mem <= '0;
    mem_wb <= '0;
    for (int i = 0; i < 24; i++) begin
      req = random_branch(br_op_e'(i % 6));
      // Second round has equal operands
      if (i / 6 == 1) req.rs2_val = req.rs1_val;
      send_branch(req, req.rs1_val, req.rs2_val);
      if (timed_out) return;
    end
  endtask

  task automatic test_forward_priority();
    br_req_t req;
    logic [31:0] alu_v;
    logic [31:0] wb_v;
    alu_v = $random(seed);
    wb_v  = $random(seed);
    // Both stages write x5 and EX/MEM is newer
    ex_mem <= '{rd: 5'd5, regwrite: 1'b1, memread: 1'b0, alures: alu_v};
    mem_wb <= '{rd: 5'd5, regwrite: 1'b1, wbres: wb_v};
    req = random_branch(BR_EQ);
    req.rs1     = 5'd5;
    req.rs2     = 5'd7;
    req.rs2_val = alu_v;
    send_branch(req, alu_v, req.rs2_val);
    if (timed_out) return;
    // Only MEM/WB matches
    mem_wb <= '{rd: 5'd9, regwrite: 1'b1, wbres: wb_v};
    req = random_branch(BR_NE);
    req.rs1     = 5'd7;
    req.rs2     = 5'd9;
    req.rs1_val = wb_v;
    send_branch(req, req.rs1_val, wb_v);
    if (timed_out) return;
    // Same ALU write on both sources
    ex_mem <= '{rd: 5'd6, regwrite: 1'b1, memread: 1'b0, alures: alu_v};
    req = random_branch(BR_EQ);
    req.rs1 = 5'd6;
    req.rs2 = 5'd6;
    send_branch(req, alu_v, alu_v);
    if (timed_out) return;
    // x0 writes never forward and both stages carry the same value
    ex_mem <= '{rd: 5'd0, regwrite: 1'b1, memread: 1'b0, alures: alu_v};
    mem_wb <= '{rd: 5'd0, regwrite: 1'b1, wbres: alu_v};
    req = random_branch(BR_EQ);
    req.rs1     = 5'd0;
    req.rs2     = 5'd0;
    req.rs1_val = ~alu_v;
    req.rs2_val = alu_v;
    send_branch(req, req.rs1_val, req.rs2_val);
    if (timed_out) return;
    // Swapped so a forward on rs2 shows up too
    req.rs1_val = alu_v;
    req.rs2_val = ~alu_v;
    send_branch(req, req.rs1_val, req.rs2_val);
    ex_mem <= '0;
    mem_wb <= '0;
  endtask

  task automatic test_load_stall();
    br_req_t req;
    logic [31:0] ld_v;
    ld_v = $random(seed);
    // Load to x12 feeds rs2
    mem_wb <= '0;
    ex_mem <= '{rd: 5'd12, regwrite: 1'b1, memread: 1'b1, alures: $random(seed)};
    req = random_branch(BR_GE);
    req.rs1 = 5'd3;
    req.rs2 = 5'd12;
    hold_stalled(req);
    // Load moves on to MEM/WB
    ex_mem <= '0;
    mem_wb <= '{rd: 5'd12, regwrite: 1'b1, wbres: ld_v};
    send_branch(req, req.rs1_val, ld_v);
    if (timed_out) return;
    // Load to x3 feeds rs1 and then retires out of view
    ex_mem <= '{rd: 5'd3, regwrite: 1'b1, memread: 1'b1, alures: $random(seed)};
    mem_wb <= '0;
    req = random_branch(BR_LT);
    req.rs1 = 5'd3;
    req.rs2 = 5'd20;
    hold_stalled(req);
    ex_mem <= '0;
    send_branch(req, req.rs1_val, req.rs2_val);
  endtask

  task automatic test_md_forward();
    md_req_t md;
    br_req_t req;
    logic [31:0] exp_md;
    md.op  = MD_MUL;
    md.a   = $random(seed);
    md.b   = $random(seed);
    md.rd  = 5'd14;
    exp_md = md_model(md.op, md.a, md.b);
    ex_mem <= '0;
    mem_wb <= '0;
    md_issue(md);
    if (timed_out) return;
    md_wait_result();
    if (timed_out) return;
    // Stale ALU value for x14 has to lose
    ex_mem <= '{rd: 5'd14, regwrite: 1'b1, memread: 1'b0, alures: ~exp_md};
    req = random_branch(BR_EQ);
    req.rs1     = 5'd14;
    req.rs2     = 5'd2;
    req.rs2_val = exp_md;
    send_branch(req, exp_md, exp_md);
    if (timed_out) return;
    // Held result on rs2 against the same value from the register file
    req = random_branch(BR_EQ);
    req.rs1     = 5'd0;
    req.rs2     = 5'd14;
    req.rs1_val = exp_md;
    send_branch(req, req.rs1_val, exp_md);
    if (timed_out) return;
    md_release(exp_md, 1);
    ex_mem <= '0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed         = 5877;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    test_err0    = 0;
    timed_out    = 1'b0;
    reset        = 1'b1;
    md_req_valid = 1'b0;
    md_req       = '0;
    md_res_ready = 1'b0;
    br_req_valid = 1'b0;
    br_req       = '0;
    ex_mem       = '0;
    mem_wb       = '0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);

    test_md_ops();
    close_test("md_ops");
    if (!timed_out) test_plain_branches();
    close_test("plain_branches");
    if (!timed_out) test_forward_priority();
    close_test("forward_priority");
    if (!timed_out) test_load_stall();
    close_test("load_stall");
    if (!timed_out) test_md_forward();
    close_test("md_forward");

    // Let the last pulses settle before counting bound failures
    repeat (3) @(posedge clk);
    errors += dut_i.asserts_i.fails;
    $display("tests run %0d, failed %0d, errors %0d, assertion failures %0d",
             tests_run, tests_failed, errors, dut_i.asserts_i.fails);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule : bru_tb

`default_nettype wire
